// File: design/frame_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module frame_store import video_pkg::*; (
	input  wire            i_clk,
	input  wire            i_wr_en,
	input  wire src_addr_t i_wr_addr,
	input  wire rgb_t      i_wr_pixel,
	input  wire src_addr_t i_rd_addr,
	output rgb_t           o_rd_pixel
);

	// One word per source pixel, row major
	localparam int DEPTH = `SRC_W * `SRC_H;

	rgb_t mem [DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// Single strobe, lands on this edge
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_pixel;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// Data one cycle after the address
	// same-cycle write to the same word returns the old value
	always_ff @(posedge i_clk) begin
		o_rd_pixel <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// File: design/scan_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module scan_timing import video_pkg::*; (
	input  wire           i_clk,
	input  wire           i_rst_n,
	output video_timing_t o_timing
);

	////////////////////////////////////////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////////////////////////////////////////

	// Position within the line, cycle 0 starts hsync
	hcount_t h_cnt;
	// Line within the frame, line 0 starts vsync
	vcount_t v_cnt;
	// Last cycle of the line
	logic h_wrap;
	// Last line of the frame
	logic v_wrap;

	assign h_wrap = (h_cnt == hcount_t'(`H_TOTAL - 1));
	assign v_wrap = (v_cnt == vcount_t'(`V_TOTAL - 1));

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			h_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + hcount_t'(1);
		end
	end

	// Steps once per line, on the horizontal wrap
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			v_cnt <= '0;
		end else if (h_wrap) begin
			if (v_wrap) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + vcount_t'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sync pulse outputs
	////////////////////////////////////////////////////////////////////////////

	// Both syncs decoded from the same counter state
	// so vsync moves on the same cycle hsync falls
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_timing <= '1;
		end else begin
			// Low for the first H_SYNC cycles of a line
			o_timing.hsync_n  <= (h_cnt >= hcount_t'(`H_SYNC));
			// Low for the first V_SYNC lines of a frame
			o_timing.vsync_n  <= (v_cnt >= vcount_t'(`V_SYNC));
			// Blanking rebuilt downstream
			o_timing.hblank_n <= 1'b1;
			o_timing.vblank_n <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/sync_to_blanking.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module sync_to_blanking import video_pkg::*; (
	input  wire                i_clk,
	input  wire                i_rst_n,
	input  wire video_timing_t i_timing,
	output video_timing_t      o_timing,
	output hcount_t            o_h,
	output vcount_t            o_v,
	output logic               o_active,
	output logic               o_locked
);

	typedef enum logic {
		UNLOCKED,
		LOCKED
	} lock_state_t;

	lock_state_t state;
	// First vsync fall seen, a full frame follows it
	logic frame_started;

	// Previous sync levels for edge detection
	logic hs_q;
	logic vs_q;
	logic hs_rise;
	logic hs_fall;
	logic vs_rise;
	logic vs_fall;

	// Cycles since hsync rose, lines since vsync rose
	hcount_t h_cnt;
	hcount_t h_cnt_next;
	vcount_t v_line;
	vcount_t v_line_next;

	logic hblank_n_next;
	logic vblank_n_next;

	////////////////////////////////////////////////////////////////////////////
	// Sync edges and porch counters
	////////////////////////////////////////////////////////////////////////////

	assign hs_rise = i_timing.hsync_n & ~hs_q;
	assign hs_fall = ~i_timing.hsync_n & hs_q;
	assign vs_rise = i_timing.vsync_n & ~vs_q;
	assign vs_fall = ~i_timing.vsync_n & vs_q;

	// Saturates so a missing sync never fakes an active region
	always_comb begin
		if (hs_rise) begin
			h_cnt_next = '0;
		end else if (h_cnt != '1) begin
			h_cnt_next = h_cnt + hcount_t'(1);
		end else begin
			h_cnt_next = h_cnt;
		end
	end

	// Line boundaries taken from hsync falls
	// vsync rise shares its cycle with an hsync fall
	always_comb begin
		if (vs_rise) begin
			v_line_next = '0;
		end else if (hs_fall && (v_line != '1)) begin
			v_line_next = v_line + vcount_t'(1);
		end else begin
			v_line_next = v_line;
		end
	end

	// Active window after the back porch, gated until locked
	assign hblank_n_next = (state == LOCKED)
		&& (h_cnt_next >= hcount_t'(`H_BACK))
		&& (h_cnt_next < hcount_t'(`H_BACK + `H_ACTIVE));
	assign vblank_n_next = (state == LOCKED)
		&& (v_line_next >= vcount_t'(`V_BACK))
		&& (v_line_next < vcount_t'(`V_BACK + `V_ACTIVE));

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			hs_q     <= 1'b1;
			vs_q     <= 1'b1;
			// Parked at saturation until the first sync edge
			h_cnt    <= '1;
			v_line   <= '1;
			o_timing <= TIMING_RESET;
			o_active <= 1'b0;
		end else begin
			hs_q     <= i_timing.hsync_n;
			vs_q     <= i_timing.vsync_n;
			h_cnt    <= h_cnt_next;
			v_line   <= v_line_next;
			// Syncs pass through with one cycle of delay
			o_timing.hsync_n  <= i_timing.hsync_n;
			o_timing.vsync_n  <= i_timing.vsync_n;
			o_timing.hblank_n <= hblank_n_next;
			o_timing.vblank_n <= vblank_n_next;
			o_active <= hblank_n_next & vblank_n_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Active position
	////////////////////////////////////////////////////////////////////////////

	// Held at zero through blanking, first active cycle reads zero
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_h <= '0;
			o_v <= '0;
		end else begin
			if (!hblank_n_next) begin
				o_h <= '0;
			end else if (o_timing.hblank_n) begin
				o_h <= o_h + hcount_t'(1);
			end
			if (!vblank_n_next) begin
				o_v <= '0;
			end else if (hs_fall && o_timing.vblank_n) begin
				o_v <= o_v + vcount_t'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Lock FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state         <= UNLOCKED;
			frame_started <= 1'b0;
		end else if (vs_fall) begin
			case (state)
				UNLOCKED: begin
					// Second vsync fall closes a complete frame
					if (frame_started) begin
						state <= LOCKED;
					end
					frame_started <= 1'b1;
				end
				default: state <= LOCKED;
			endcase
		end
	end

	assign o_locked = (state == LOCKED);

endmodule

`default_nettype wire

// File: design/upscale_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module upscale_reader import video_pkg::*; (
	input  wire                i_clk,
	input  wire                i_rst_n,
	input  wire video_timing_t i_timing,
	input  wire hcount_t       i_h,
	input  wire vcount_t       i_v,
	input  wire                i_active,
	output src_addr_t          o_rd_addr,
	input  wire rgb_t          i_rd_pixel,
	output video_timing_t      o_video,
	output rgb_t               o_pixel
);

	////////////////////////////////////////////////////////////////////////////
	// Nearest neighbour address
	////////////////////////////////////////////////////////////////////////////

	// Output position halved in both directions
	src_addr_t src_col;
	src_addr_t src_row;
	src_addr_t next_addr;

	assign src_col = src_addr_t'(i_h >> 1);
	assign src_row = src_addr_t'(i_v >> 1);

	// Row major, SRC_W words per row
	assign next_addr = src_addr_t'(src_row * `SRC_W) + src_col;

	// Stage 1, address into the store
	always_ff @(posedge i_clk) begin
		o_rd_addr <= next_addr;
	end

	////////////////////////////////////////////////////////////////////////////
	// Timing alignment
	////////////////////////////////////////////////////////////////////////////

	// Timing and active flag follow the pixel through both stages
	video_timing_t timing_s1;
	video_timing_t timing_s2;
	logic          active_s1;
	logic          active_s2;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			timing_s1 <= TIMING_RESET;
			timing_s2 <= TIMING_RESET;
			active_s1 <= 1'b0;
			active_s2 <= 1'b0;
		end else begin
			// Stage 1 matches the address register
			timing_s1 <= i_timing;
			active_s1 <= i_active;
			// Stage 2 matches the memory read
			timing_s2 <= timing_s1;
			active_s2 <= active_s1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output stream
	////////////////////////////////////////////////////////////////////////////

	assign o_video = timing_s2;

	// Black outside the active area
	assign o_pixel = active_s2 ? i_rd_pixel : '0;

endmodule

`default_nettype wire

// File: design/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Horizontal timing in clock cycles
`define H_ACTIVE 16
`define H_FRONT  2
`define H_SYNC   3
`define H_BACK   3
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_ACTIVE 8
`define V_FRONT  1
`define V_SYNC   2
`define V_BACK   1
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Source frame held in the store, doubled on output
`define SRC_W 8
`define SRC_H 4

// Bits per colour component
`define COMP_W 4

`endif

// File: design/video_pkg.sv
`default_nettype none

`include "video_macros.svh"

package video_pkg;

	// Counter and address widths follow the timing macros
	localparam int HCOUNT_W   = $clog2(`H_TOTAL);
	localparam int VCOUNT_W   = $clog2(`V_TOTAL);
	localparam int SRC_ADDR_W = $clog2(`SRC_W * `SRC_H);

	typedef logic [`COMP_W-1:0] comp_t;

	typedef struct packed {
		comp_t red;
		comp_t green;
		comp_t blue;
	} rgb_t;

	typedef logic [HCOUNT_W-1:0]   hcount_t;
	typedef logic [VCOUNT_W-1:0]   vcount_t;
	typedef logic [SRC_ADDR_W-1:0] src_addr_t;

	// All four bits active low
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank_n;
		logic vblank_n;
	} video_timing_t;

	// Syncs idle, picture blanked
	localparam video_timing_t TIMING_RESET = '{
		hsync_n:  1'b1,
		vsync_n:  1'b1,
		hblank_n: 1'b0,
		vblank_n: 1'b0
	};

endpackage

`default_nettype wire

// File: design/video_upscaler.sv
`timescale 1ns/1ns
`default_nettype none

module video_upscaler import video_pkg::*; (
	input  wire                i_clk,
	input  wire                i_rst_n,
	// Source frame write port
	input  wire                i_wr_en,
	input  wire src_addr_t     i_wr_addr,
	input  wire rgb_t          i_wr_pixel,
	// Scaled output stream
	output wire video_timing_t o_video,
	output wire rgb_t          o_pixel,
	output wire                o_locked
);

	// Bare syncs from the generator
	video_timing_t raw_timing;
	// Syncs plus rebuilt blanking
	video_timing_t blank_timing;
	// Active position and its valid level
	hcount_t       pos_h;
	vcount_t       pos_v;
	logic          pos_active;
	// Store read side
	src_addr_t     rd_addr;
	rgb_t          rd_pixel;

	////////////////////////////////////////////////////////////////////////////
	// Output timing chain
	////////////////////////////////////////////////////////////////////////////

	scan_timing u_scan_timing (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.o_timing (raw_timing)
	);

	sync_to_blanking u_sync_to_blanking (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_timing (raw_timing),
		.o_timing (blank_timing),
		.o_h      (pos_h),
		.o_v      (pos_v),
		.o_active (pos_active),
		.o_locked (o_locked)
	);

	////////////////////////////////////////////////////////////////////////////
	// Source frame and scaler
	////////////////////////////////////////////////////////////////////////////

	frame_store u_frame_store (
		.i_clk      (i_clk),
		.i_wr_en    (i_wr_en),
		.i_wr_addr  (i_wr_addr),
		.i_wr_pixel (i_wr_pixel),
		.i_rd_addr  (rd_addr),
		.o_rd_pixel (rd_pixel)
	);

	upscale_reader u_upscale_reader (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_timing   (blank_timing),
		.i_h        (pos_h),
		.i_v        (pos_v),
		.i_active   (pos_active),
		.o_rd_addr  (rd_addr),
		.i_rd_pixel (rd_pixel),
		.o_video    (o_video),
		.o_pixel    (o_pixel)
	);

endmodule

`default_nettype wire

// File: dv/video_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module video_checker import video_pkg::*; (
	input  wire                           i_clk,
	input  wire                           i_enable,
	input  wire rgb_t [`SRC_W*`SRC_H-1:0] i_model,
	input  wire video_timing_t            i_video,
	input  wire rgb_t                     i_pixel,
	output int                            o_active_errors,
	output int                            o_blank_errors,
	output int                            o_active_seen,
	output int                            o_blank_seen
);

	int active_errors = 0;
	int blank_errors = 0;
	int active_seen = 0;
	int blank_seen = 0;

	// Output position rebuilt from the blank edges
	int   h_pos = 0;
	int   v_pos = 0;
	logic hb_q = 1'b0;

	assign o_active_errors = active_errors;
	assign o_blank_errors  = blank_errors;
	assign o_active_seen   = active_seen;
	assign o_blank_seen    = blank_seen;

	////////////////////////////////////////////////////////////////////////////
	// Reference pixel rule
	////////////////////////////////////////////////////////////////////////////

	// Source pixel at half the position and black in blanking
	function automatic rgb_t expected_pixel(input int h, input int v, input logic active);
		int col;
		int row;
		col = h / 2;
		row = v / 2;
		if (!active) begin
			return '0;
		end
		// Outside the source means the position went wrong
		if (col >= `SRC_W || row >= `SRC_H) begin
			return 'x;
		end
		return i_model[row * `SRC_W + col];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare half a cycle after the outputs move
	////////////////////////////////////////////////////////////////////////////

	always @(negedge i_clk) begin : compare_pixels
		logic active;
		rgb_t expected;
		active = i_video.hblank_n && i_video.vblank_n;
		if (i_enable) begin
			expected = expected_pixel(h_pos, v_pos, active);
			if (active) begin
				active_seen++;
			end else begin
				blank_seen++;
			end
			if (i_pixel !== expected) begin
				if (active) begin
					active_errors++;
				end else begin
					blank_errors++;
				end
				$display("error %0t ns: o_pixel at h=%0d v=%0d expected %03h got %03h",
					$time, h_pos, v_pos, expected, i_pixel);
			end
		end
		// Column counts active cycles of the line
		if (!i_video.hblank_n) begin
			h_pos = 0;
		end else if (i_video.vblank_n) begin
			h_pos++;
		end
		// Next line once hblank falls inside the active area
		if (!i_video.vblank_n) begin
			v_pos = 0;
		end else if (hb_q && !i_video.hblank_n) begin
			v_pos++;
		end
		hb_q = i_video.hblank_n;
	end

endmodule

`default_nettype wire

// File: dv/video_upscaler_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module video_upscaler_properties import video_pkg::*; (
	input wire                i_clk,
	input wire                i_rst_n,
	input wire video_timing_t i_video,
	input wire rgb_t          i_pixel
);

	// Low cycles so far in the current sync pulse
	int hs_low;
	int vs_low;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			hs_low <= 0;
			vs_low <= 0;
		end else begin
			hs_low <= i_video.hsync_n ? 0 : hs_low + 1;
			vs_low <= i_video.vsync_n ? 0 : vs_low + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sync widths
	////////////////////////////////////////////////////////////////////////////

	// hsync pulse is H_SYNC cycles
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_video.hsync_n) |-> (hs_low == `H_SYNC))
		else $error("hsync_n pulse was %0d cycles wide", hs_low);

	// vsync pulse is V_SYNC whole lines
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_video.vsync_n) |-> (vs_low == `V_SYNC * `H_TOTAL))
		else $error("vsync_n pulse was %0d cycles wide", vs_low);

	// Black whenever either blank is active
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_video.hblank_n && i_video.vblank_n) |-> (i_pixel == '0))
		else $error("o_pixel is %03h during blanking", i_pixel);

endmodule

bind upscale_reader video_upscaler_properties u_properties (
	.i_clk   (i_clk),
	.i_rst_n (i_rst_n),
	.i_video (o_video),
	.i_pixel (o_pixel)
);

`default_nettype wire

// File: dv/video_upscaler_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module video_upscaler_tb import video_pkg::*; ();

	localparam int NPIX         = `SRC_W * `SRC_H;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int FRAME_ACTIVE = `H_ACTIVE * `V_ACTIVE;
	localparam int LINE_LIMIT   = 2 * `H_TOTAL;
	localparam int FRAME_LIMIT  = 2 * FRAME_CYCLES;

	logic          clk = 1'b0;
	logic          rst_n;
	logic          wr_en;
	src_addr_t     wr_addr;
	rgb_t          wr_pixel;
	video_timing_t video;
	rgb_t          pixel;
	logic          locked;

	// Checker control and counters
	logic check_en;
	int   active_errors;
	int   blank_errors;
	int   active_seen;
	int   blank_seen;

	// What the store should hold
	rgb_t [NPIX-1:0] frame_model;
	logic [16:0]     lfsr = 17'd66593;
	int              failures = 0;
	int              tests_bad = 0;

	always #4 clk = ~clk;

	video_upscaler UUT (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_wr_en    (wr_en),
		.i_wr_addr  (wr_addr),
		.i_wr_pixel (wr_pixel),
		.o_video    (video),
		.o_pixel    (pixel),
		.o_locked   (locked)
	);

	video_checker u_checker (
		.i_clk           (clk),
		.i_enable        (check_en),
		.i_model         (frame_model),
		.i_video         (video),
		.i_pixel         (pixel),
		.o_active_errors (active_errors),
		.o_blank_errors  (blank_errors),
		.o_active_seen   (active_seen),
		.o_blank_seen    (blank_seen)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	// One LFSR step per bit
	task automatic random_pixel(output rgb_t p);
		logic [11:0] bits;
		bits = '0;
		for (int i = 0; i < 12; i++) begin
			bits = {bits[10:0], lfsr[16]};
			lfsr = lfsr_next(lfsr);
		end
		p = bits;
	endtask

	// Whole frame, one word per cycle, model kept in step
	task automatic load_frame();
		rgb_t p;
		for (int a = 0; a < NPIX; a++) begin
			random_pixel(p);
			@(posedge clk);
			#1;
			wr_en = 1'b1;
			wr_addr = src_addr_t'(a);
			wr_pixel = p;
			frame_model[a] = p;
		end
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("error %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
			failures++;
		end
	endtask

	task automatic report_test(input int num, input string name, input bit ok);
		$display("test %0d %s: %s", num, name, ok ? "ok" : "ERRORS");
		if (!ok) begin
			tests_bad++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Waits, all bounded
	////////////////////////////////////////////////////////////////////////////

	function automatic logic sync_level(input int which);
		return (which == 0) ? video.hsync_n : video.vsync_n;
	endfunction

	// which 0 is hsync, 1 is vsync
	task automatic wait_sync_fall(input int which, input int limit, output bit seen);
		logic prev;
		int   n;
		seen = 1'b0;
		prev = sync_level(which);
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = prev && !sync_level(which);
			prev = sync_level(which);
			n++;
		end
		if (!seen) begin
			$display("timeout: no %s falling edge within %0d cycles",
				(which == 0) ? "hsync" : "vsync", limit);
			failures++;
		end
	endtask

	task automatic wait_lock(input int limit);
		int n;
		n = 0;
		while (!locked && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!locked) begin
			$display("timeout: o_locked did not rise within %0d cycles", limit);
			failures++;
		end
	endtask

	// Starts on the first hsync low cycle, ends on the next one
	task automatic measure_line();
		int   cycles;
		int   hs_low;
		int   hb_high;
		logic prev;
		bit   seen;
		cycles = 0;
		hs_low = 0;
		hb_high = 0;
		seen = 1'b0;
		prev = video.hsync_n;
		while (!seen && cycles < LINE_LIMIT) begin
			hs_low = hs_low + (video.hsync_n ? 0 : 1);
			hb_high = hb_high + (video.hblank_n ? 1 : 0);
			cycles++;
			@(negedge clk);
			seen = prev && !video.hsync_n;
			prev = video.hsync_n;
		end
		if (!seen) begin
			$display("timeout: line did not end within %0d cycles", LINE_LIMIT);
			failures++;
		end else begin
			check_value("o_video line length", `H_TOTAL, cycles);
			check_value("o_video.hsync_n low cycles", `H_SYNC, hs_low);
			check_value("o_video.hblank_n high cycles", `H_ACTIVE, hb_high);
		end
	endtask

	// Frame length and active line count between vsync falls
	task automatic measure_frame();
		int   cycles;
		int   lines;
		logic hb_prev;
		logic vs_prev;
		bit   seen;
		wait_sync_fall(1, FRAME_LIMIT, seen);
		cycles = 0;
		lines = 0;
		seen = 1'b0;
		hb_prev = video.hblank_n;
		vs_prev = video.vsync_n;
		while (!seen && cycles < FRAME_LIMIT) begin
			if (!hb_prev && video.hblank_n && video.vblank_n) begin
				lines++;
			end
			hb_prev = video.hblank_n;
			cycles++;
			@(negedge clk);
			seen = vs_prev && !video.vsync_n;
			vs_prev = video.vsync_n;
		end
		if (!seen) begin
			$display("timeout: frame did not end within %0d cycles", FRAME_LIMIT);
			failures++;
		end else begin
			check_value("o_video frame length", FRAME_CYCLES, cycles);
			check_value("o_video.vblank_n active lines", `V_ACTIVE, lines);
		end
	endtask

	// Checker on from one vsync fall to a later one
	task automatic run_checked_frames(input int frames);
		bit seen;
		wait_sync_fall(1, FRAME_LIMIT, seen);
		@(posedge clk);
		#1;
		check_en = 1'b1;
		for (int f = 0; f < frames; f++) begin
			wait_sync_fall(1, FRAME_LIMIT, seen);
		end
		@(posedge clk);
		#1;
		check_en = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		bit seen;
		int f0;
		int a0;
		int b0;
		int ea0;
		int eb0;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_pixel = '0;
		check_en = 1'b0;
		frame_model = '0;

		// Reset values, sampled in the last reset cycle
		f0 = failures;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("o_locked", 0, int'(locked));
		check_value("o_video.hblank_n", 0, int'(video.hblank_n));
		check_value("o_video.vblank_n", 0, int'(video.vblank_n));
		check_value("o_video.hsync_n", 1, int'(video.hsync_n));
		check_value("o_video.vsync_n", 1, int'(video.vsync_n));
		check_value("o_pixel", 0, int'(pixel));
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		// First frame goes in while the timing chain is still unlocked
		load_frame();
		wait_lock(3 * FRAME_CYCLES - NPIX - 1);
		report_test(1, "reset state and lock", failures == f0);

		f0 = failures;
		wait_sync_fall(0, LINE_LIMIT, seen);
		for (int l = 0; l < `V_TOTAL; l++) begin
			measure_line();
		end
		measure_frame();
		report_test(2, "line and frame timing", failures == f0);

		f0 = failures;
		a0 = active_seen;
		b0 = blank_seen;
		ea0 = active_errors;
		eb0 = blank_errors;
		run_checked_frames(2);
		check_value("checked active pixels", 2 * FRAME_ACTIVE, active_seen - a0);
		report_test(3, "doubled pixels over two frames",
			failures == f0 && active_errors == ea0);

		f0 = failures;
		if (blank_seen - b0 < 2 * (FRAME_CYCLES - FRAME_ACTIVE)) begin
			$display("too few blanked cycles were checked: %0d", blank_seen - b0);
			failures++;
		end
		report_test(4, "zero pixels in blanking", failures == f0 && blank_errors == eb0);

		// Rewrite lands a few lines into a frame
		f0 = failures;
		a0 = active_seen;
		ea0 = active_errors + blank_errors;
		repeat (5) wait_sync_fall(0, LINE_LIMIT, seen);
		load_frame();
		run_checked_frames(1);
		check_value("checked active pixels", FRAME_ACTIVE, active_seen - a0);
		report_test(5, "frame rewrite in operation",
			failures == f0 && active_errors + blank_errors == ea0);

		$display("tests 5, tests with errors %0d, pixel mismatches %0d, other failures %0d",
			tests_bad, active_errors + blank_errors, failures);
		if (tests_bad == 0 && failures == 0 && active_errors + blank_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f video_upscaler.f \
	--top-module video_upscaler_tb -Mdir obj_dir || exit 1
out=$(./obj_dir/Vvideo_upscaler_tb)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: video_upscaler.f
+incdir+design
design/video_pkg.sv
design/scan_timing.sv
design/sync_to_blanking.sv
design/frame_store.sv
design/upscale_reader.sv
design/video_upscaler.sv
dv/video_checker.sv
dv/video_upscaler_properties.sv
dv/video_upscaler_tb.sv
